/* activity_indicator.sv */
// Activity indicator
// Dimmed pulse on SD or DRAM activity, merged into GPIO output bit 0
`timescale 1ns/1ps
`default_nettype none

module activity_indicator #(
	parameter int GPIO_W = 8,
	parameter int CNTR_W = 1
) (
	input  wire              clk_2x_w,
	input  wire              rst_p,
	input  wire              sd_di_i,
	input  wire              sd_do_i,
	input  wire              dram_init_error_i,
	input  wire [GPIO_W-1:0] gpio_out_i,
	output logic [GPIO_W-1:0] gp_o
);

	logic activity_q;
	logic [CNTR_W-1:0] act_cntr_q;

	// A pulse blocks the following cycles until the counter drains
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			activity_q <= 1'b0;
			act_cntr_q <= '0;
		end else if (act_cntr_q != '0) begin
			activity_q <= 1'b0;
			act_cntr_q <= act_cntr_q - 1'b1;
		end else if (~(sd_di_i & sd_do_i) | dram_init_error_i) begin
			activity_q <= 1'b1;
			act_cntr_q <= '1;
		end else begin
			activity_q <= 1'b0;
		end
	end

	assign gp_o = gpio_out_i | GPIO_W'(activity_q);

endmodule

`default_nettype wire

/* bus_router.sv */
// Peripheral bus router
// Decodes the word address to a slave, answers invalid addresses
// with zero and muxes the registered read data back to the master
`timescale 1ns/1ps
`default_nettype none

module bus_router (
	input  wire                            clk_2x_w,
	input  wire                            sys_rst_i,
	input  wire soc_bus_pkg::pi1_req_t     bus_req_i,
	output soc_bus_pkg::pi1_rsp_t          bus_rsp_o,
	output soc_bus_pkg::pi1_req_t          devtbl_req_o,
	output soc_bus_pkg::pi1_req_t          gpio_req_o,
	input  wire [soc_bus_pkg::DATA_W-1:0]  devtbl_rdata_i,
	input  wire [soc_bus_pkg::DATA_W-1:0]  gpio_rdata_i
);

	logic rdy;
	logic accept;
	logic [soc_map_pkg::SLV_IDX_W-1:0] slv;
	logic [soc_map_pkg::SLV_IDX_W-1:0] rd_slv_q;

	assign rdy    = ~sys_rst_i;
	assign accept = rdy && (bus_req_i.op != soc_bus_pkg::NOP);

	always_comb begin
		if (bus_req_i.addr < soc_bus_pkg::ADDR_W'(soc_map_pkg::GPIO_BASE)) begin
			slv = soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_DEVTBL);
		end else if (bus_req_i.addr < soc_bus_pkg::ADDR_W'(soc_map_pkg::GPIO_BASE +
				soc_map_pkg::GPIO_WORDS)) begin
			slv = soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_GPIO);
		end else begin
			slv = soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_INVALID);
		end
	end

	// Slaves see their own offset, unselected ones see NOP
	always_comb begin
		devtbl_req_o      = bus_req_i;
		devtbl_req_o.addr = bus_req_i.addr - soc_bus_pkg::ADDR_W'(soc_map_pkg::DEVTBL_BASE);
		gpio_req_o        = bus_req_i;
		gpio_req_o.addr   = bus_req_i.addr - soc_bus_pkg::ADDR_W'(soc_map_pkg::GPIO_BASE);
		if (!accept || slv != soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_DEVTBL)) begin
			devtbl_req_o.op = soc_bus_pkg::NOP;
		end
		if (!accept || slv != soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_GPIO)) begin
			gpio_req_o.op = soc_bus_pkg::NOP;
		end
	end

	// Remember which slave owns the read data of the next cycle
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rd_slv_q <= soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_INVALID);
		end else if (accept) begin
			rd_slv_q <= slv;
		end
	end

	always_comb begin
		bus_rsp_o.rdy = rdy;
		case (rd_slv_q)
			soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_DEVTBL): bus_rsp_o.data = devtbl_rdata_i;
			soc_map_pkg::SLV_IDX_W'(soc_map_pkg::SLV_GPIO):   bus_rsp_o.data = gpio_rdata_i;
			// Invalid device reads as zero
			default: bus_rsp_o.data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* device_table.sv */
// Device table
// Read-only description of every slave plus the software reset
// control register at word 0
`timescale 1ns/1ps
`default_nettype none

module device_table (
	input  wire                           clk_2x_w,
	input  wire                           sys_rst_i,
	input  wire soc_bus_pkg::pi1_req_t    req_i,
	output logic [soc_bus_pkg::DATA_W-1:0] rdata_o,
	output soc_map_pkg::rst_ctrl_t        rst_ctrl_o
);

	logic [soc_bus_pkg::DATA_W-1:0] rd_val;
	logic [soc_bus_pkg::ADDR_W-1:0] entry;
	logic [soc_map_pkg::SLV_IDX_W-1:0] slv;
	soc_map_pkg::rst_ctrl_t rst_ctrl_q;

	// Words 2+2k and 3+2k describe slave k
	assign entry = (req_i.addr - soc_bus_pkg::ADDR_W'(2)) >> 1;
	assign slv   = entry[soc_map_pkg::SLV_IDX_W-1:0];

	always_comb begin
		rd_val = '0;
		if (req_i.addr == '0) begin
			rd_val = soc_bus_pkg::DATA_W'(rst_ctrl_q);
		end else if (req_i.addr == soc_bus_pkg::ADDR_W'(1)) begin
			rd_val = soc_bus_pkg::DATA_W'(soc_map_pkg::SLV_COUNT);
		end else if (entry < soc_bus_pkg::ADDR_W'(soc_map_pkg::SLV_COUNT)) begin
			if (!req_i.addr[0]) begin
				// Interrupt use in the top bit, id in the low half
				rd_val = {soc_map_pkg::DEV_USEINTR[slv], 15'd0, soc_map_pkg::DEV_ID[slv]};
			end else begin
				rd_val = soc_map_pkg::DEV_MAPSZ[slv];
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rst_ctrl_q <= '0;
		end else if (req_i.op == soc_bus_pkg::WR && req_i.sel[0] && req_i.addr == '0) begin
			rst_ctrl_q <= soc_map_pkg::rst_ctrl_t'(req_i.data[1:0]);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.op == soc_bus_pkg::RD) begin
			rdata_o <= rd_val;
		end
	end

	assign rst_ctrl_o = rst_ctrl_q;

endmodule

`default_nettype wire

/* gpio_port.sv */
// GPIO port
// Output register at word 0, two-flop synchronized inputs at word 1
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input  wire                                clk_2x_w,
	input  wire                                sys_rst_i,
	input  wire soc_bus_pkg::pi1_req_t         req_i,
	input  wire [soc_map_pkg::GPIO_COUNT-1:0]  gp_i,
	output logic [soc_bus_pkg::DATA_W-1:0]     rdata_o,
	output logic [soc_map_pkg::GPIO_COUNT-1:0] gpio_out_o
);

	logic [soc_map_pkg::GPIO_COUNT-1:0] gp_meta_q;
	logic [soc_map_pkg::GPIO_COUNT-1:0] gp_sync_q;
	logic [soc_map_pkg::GPIO_COUNT-1:0] out_q;

	always_ff @(posedge clk_2x_w) begin
		gp_meta_q <= gp_i;
		gp_sync_q <= gp_meta_q;
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (req_i.op == soc_bus_pkg::WR && req_i.sel[0] && req_i.addr == '0) begin
			out_q <= req_i.data[soc_map_pkg::GPIO_COUNT-1:0];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.op == soc_bus_pkg::RD) begin
			if (req_i.addr == '0) begin
				rdata_o <= soc_bus_pkg::DATA_W'(out_q);
			end else if (req_i.addr == soc_bus_pkg::ADDR_W'(1)) begin
				rdata_o <= soc_bus_pkg::DATA_W'(gp_sync_q);
			end else begin
				rdata_o <= '0;
			end
		end
	end

	assign gpio_out_o = out_q;

endmodule

`default_nettype wire

/* list.f */
soc_bus_pkg.sv
soc_map_pkg.sv
reset_sequencer.sv
device_table.sv
gpio_port.sv
activity_indicator.sv
bus_router.sv
platform_ctrl_top.sv
platform_ctrl_chk.sv
tb_platform_ctrl.sv

/* platform_ctrl_chk.sv */
// Bus and activity checker
// Concurrent assertions bound into the platform control top level
`timescale 1ns/1ps
`default_nettype none

module platform_ctrl_chk (
	input wire                                clk_2x_w,
	input wire                                rst_p,
	input wire                                rst_i,
	input wire soc_bus_pkg::pi1_req_t         bus_req_i,
	input wire soc_bus_pkg::pi1_rsp_t         bus_rsp_i,
	input wire [soc_map_pkg::GPIO_COUNT-1:0]  gp_i,
	input wire [soc_map_pkg::GPIO_COUNT-1:0]  gpio_out_i
);

	logic activity;

	// Pulse is only visible while the register bit is clear
	assign activity = gp_i[0] & ~gpio_out_i[0];

	rdy_low_in_reset: assert property (@(posedge clk_2x_w) rst_i |-> !bus_rsp_i.rdy)
		else begin
			$error("bus ready high while system reset is active");
			tb_platform_ctrl.assert_errors = tb_platform_ctrl.assert_errors + 1;
		end

	no_rw_op: assert property (@(posedge clk_2x_w) bus_req_i.op != soc_bus_pkg::RW)
		else begin
			$error("reserved RW operation issued on the bus");
			tb_platform_ctrl.assert_errors = tb_platform_ctrl.assert_errors + 1;
		end

	single_pulse: assert property (@(posedge clk_2x_w) disable iff (rst_p)
			activity |=> !activity)
		else begin
			$error("activity pulse high on two consecutive cycles");
			tb_platform_ctrl.assert_errors = tb_platform_ctrl.assert_errors + 1;
		end

endmodule

`default_nettype wire

/* platform_ctrl_top.sv */
// Platform control top level
// Reset sequencing, device table, GPIO with activity indicator and
// the peripheral bus decode behind one bus master port
`timescale 1ns/1ps
`default_nettype none

module platform_ctrl_top (
	input  wire                                clk_2x_w,
	input  wire                                rst_p,
	input  wire                                pll_locked_i,
	input  wire                                cpu_rst_req_i,
	input  wire soc_bus_pkg::pi1_req_t         bus_req_i,
	output soc_bus_pkg::pi1_rsp_t              bus_rsp_o,
	input  wire [soc_map_pkg::GPIO_COUNT-1:0]  gp_i,
	output logic [soc_map_pkg::GPIO_COUNT-1:0] gp_o,
	input  wire                                sd_di_i,
	input  wire                                sd_do_i,
	input  wire                                dram_init_error_i,
	output logic                               rst_o,
	output logic                               cold_rst_o
);

	logic sys_rst;
	soc_map_pkg::rst_ctrl_t rst_ctrl;
	soc_bus_pkg::pi1_req_t devtbl_req;
	soc_bus_pkg::pi1_req_t gpio_req;
	logic [soc_bus_pkg::DATA_W-1:0] devtbl_rdata;
	logic [soc_bus_pkg::DATA_W-1:0] gpio_rdata;
	logic [soc_map_pkg::GPIO_COUNT-1:0] gpio_out;

	reset_sequencer reset_sequencer_i (
		.clk_2x_w      (clk_2x_w),
		.rst_p         (rst_p),
		.pll_locked_i  (pll_locked_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.rst_ctrl_i    (rst_ctrl),
		.rst_o         (sys_rst),
		.cold_rst_o    (cold_rst_o)
	);

	bus_router bus_router_i (
		.clk_2x_w       (clk_2x_w),
		.sys_rst_i      (sys_rst),
		.bus_req_i      (bus_req_i),
		.bus_rsp_o      (bus_rsp_o),
		.devtbl_req_o   (devtbl_req),
		.gpio_req_o     (gpio_req),
		.devtbl_rdata_i (devtbl_rdata),
		.gpio_rdata_i   (gpio_rdata)
	);

	device_table device_table_i (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst),
		.req_i      (devtbl_req),
		.rdata_o    (devtbl_rdata),
		.rst_ctrl_o (rst_ctrl)
	);

	gpio_port gpio_port_i (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst),
		.req_i      (gpio_req),
		.gp_i       (gp_i),
		.rdata_o    (gpio_rdata),
		.gpio_out_o (gpio_out)
	);

	// Runs from the board reset so it keeps blinking through software resets
	activity_indicator #(
		.GPIO_W (soc_map_pkg::GPIO_COUNT),
		.CNTR_W (soc_map_pkg::ACT_CNTR_W)
	) activity_indicator_i (
		.clk_2x_w          (clk_2x_w),
		.rst_p             (rst_p),
		.sd_di_i           (sd_di_i),
		.sd_do_i           (sd_do_i),
		.dram_init_error_i (dram_init_error_i),
		.gpio_out_i        (gpio_out),
		.gp_o              (gp_o)
	);

	assign rst_o = sys_rst;

endmodule

`default_nettype wire

/* reset_sequencer.sv */
// System reset sequencer
// Decodes the software reset bits, latches power-off and stretches
// the system reset with a reload and count-down counter
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
	input  wire                         clk_2x_w,
	input  wire                         rst_p,
	input  wire                         pll_locked_i,
	input  wire                         cpu_rst_req_i,
	input  wire soc_map_pkg::rst_ctrl_t rst_ctrl_i,
	output logic                        rst_o,
	output logic                        cold_rst_o
);

	logic sw_cold;
	logic sw_warm;
	logic sw_pwroff;
	logic hold;
	logic pwroff_q;
	logic [soc_map_pkg::RST_CNTR_W-1:0] rst_cntr_q;

	assign sw_cold   = rst_ctrl_i.rst0 & rst_ctrl_i.rst1;
	assign sw_warm   = ~rst_ctrl_i.rst0 & rst_ctrl_i.rst1;
	assign sw_pwroff = rst_ctrl_i.rst0 & ~rst_ctrl_i.rst1;

	assign hold = rst_p | cpu_rst_req_i | sw_warm | sw_cold;

	// Reload while any request holds, then count down to zero
	always_ff @(posedge clk_2x_w) begin
		if (hold) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Only the board reset brings the system back from power-off
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign rst_o      = ~pll_locked_i | pwroff_q | (rst_cntr_q != '0);
	assign cold_rst_o = sw_cold;

endmodule

`default_nettype wire

/* soc_bus_pkg.sv */
// Peripheral bus definitions
// Widths, operation encoding and the request and response bundles
`default_nettype none

package soc_bus_pkg;

	localparam int DATA_W = 32;
	// Word address, byte offset already removed
	localparam int ADDR_W = 10;
	localparam int SEL_W = DATA_W / 8;

	// RW is reserved and never issued by the master
	typedef enum logic [1:0] {
		NOP = 2'd0,
		WR  = 2'd1,
		RD  = 2'd2,
		RW  = 2'd3
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t             op;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   data;
		logic [SEL_W-1:0]    sel;
	} pi1_req_t;

	typedef struct packed {
		logic [DATA_W-1:0]   data;
		logic                rdy;
	} pi1_rsp_t;

endpackage

`default_nettype wire

/* soc_map_pkg.sv */
// Platform address map
// Slave indices, map ranges, device table contents and platform constants
`default_nettype none

package soc_map_pkg;

	localparam int SLV_DEVTBL  = 0;
	localparam int SLV_GPIO    = 1;
	localparam int SLV_INVALID = 2;
	localparam int SLV_COUNT   = 3;
	localparam int SLV_IDX_W   = $clog2(SLV_COUNT);

	// Word ranges, everything above GPIO falls to the invalid device
	localparam int DEVTBL_BASE  = 0;
	localparam int DEVTBL_WORDS = 64;
	localparam int GPIO_BASE    = 64;
	localparam int GPIO_WORDS   = 64;

	// Per-slave table contents, index 0 in the lowest slot
	localparam logic [SLV_COUNT-1:0][15:0] DEV_ID = {16'd0, 16'd6, 16'd7};
	localparam logic [SLV_COUNT-1:0] DEV_USEINTR = 3'b010;
	localparam logic [SLV_COUNT-1:0][31:0] DEV_MAPSZ = {32'd3584, 32'd256, 32'd256};

	localparam int GPIO_COUNT = 8;

	// Short hold for simulation, 63 cycles
	localparam int RST_CNTR_W = 6;

	// Dims the activity indicator
	localparam int ACT_CNTR_W = 1;

	// rst0 sits in bit 0 of the control word
	typedef struct packed {
		logic rst1;
		logic rst0;
	} rst_ctrl_t;

endpackage

`default_nettype wire

/* tb_platform_ctrl.sv */
// Platform control testbench
// Random bus traffic from an LCG checked against a model of the device
// table, GPIO register, reset sequencing and activity indicator
`timescale 1ns/1ps
`default_nettype none

module tb_platform_ctrl;

	localparam int N_DEVTBL = 40;
	localparam int N_GPIO = 24;
	localparam int N_INVALID = 16;
	localparam int N_ACT = 80;
	localparam int N_TXN = N_DEVTBL + 3 * N_GPIO + 2 * N_INVALID + N_ACT + 40;
	localparam int N_RESETS = 8;
	localparam int WATCH_CYCLES = N_TXN * 4 + N_RESETS * 80;

	logic clk_2x_w;
	logic rst_p;
	logic pll_locked;
	logic cpu_rst_req;
	soc_bus_pkg::pi1_req_t bus_req;
	soc_bus_pkg::pi1_rsp_t bus_rsp;
	logic [7:0] gp_in;
	logic [7:0] gp_out;
	logic sd_di;
	logic sd_do;
	logic dram_init_error;
	logic rst_out;
	logic cold_rst;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;
	int assert_errors = 0;
	logic [31:0] lcg_state = 32'h63a020d8;
	logic [7:0] gpio_model = 8'd0;
	logic act_exp = 1'b0;
	logic act_cnt = 1'b0;
	logic act_cond = 1'b0;

	// Device table contents, slave k in entry k
	int dev_id [3] = '{7, 6, 0};
	bit dev_intr [3] = '{1'b0, 1'b1, 1'b0};
	int dev_size [3] = '{256, 256, 3584};

	platform_ctrl_top platform_ctrl_top_i (
		.clk_2x_w          (clk_2x_w),
		.rst_p             (rst_p),
		.pll_locked_i      (pll_locked),
		.cpu_rst_req_i     (cpu_rst_req),
		.bus_req_i         (bus_req),
		.bus_rsp_o         (bus_rsp),
		.gp_i              (gp_in),
		.gp_o              (gp_out),
		.sd_di_i           (sd_di),
		.sd_do_i           (sd_do),
		.dram_init_error_i (dram_init_error),
		.rst_o             (rst_out),
		.cold_rst_o        (cold_rst)
	);

	bind platform_ctrl_top platform_ctrl_chk platform_ctrl_chk_i (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.rst_i      (rst_o),
		.bus_req_i  (bus_req_i),
		.bus_rsp_i  (bus_rsp_o),
		.gp_i       (gp_o),
		.gpio_out_i (gpio_out)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #4 clk_2x_w = ~clk_2x_w;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_2x_w);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {8'd0, lcg_state[31:8]};
	endfunction

	// Expected word from the table layout, control register assumed clear
	function automatic logic [31:0] devtbl_word(input int w);
		int k;
		k = (w - 2) / 2;
		if (w == 1)
			return 32'd3;
		if (w < 2 || k >= 3)
			return 32'd0;
		if (w % 2 == 0)
			return {dev_intr[k], 15'd0, 16'(dev_id[k])};
		return 32'(dev_size[k]);
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic test_end(input string name);
		tests_run++;
		if (errors != test_err_base)
			tests_failed++;
		$display("test %-16s done, %0d errors", name, errors - test_err_base);
		test_err_base = errors;
	endtask

	// One transfer, ends at the falling edge where read data is valid
	task automatic bus_access(input soc_bus_pkg::pi1_op_t op, input logic [9:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel,
			output logic [31:0] rdata, output logic rdy);
		soc_bus_pkg::pi1_req_t req;
		req.op = op;
		req.addr = addr;
		req.data = wdata;
		req.sel = sel;
		@(posedge clk_2x_w);
		bus_req <= req;
		@(negedge clk_2x_w);
		while (!bus_rsp.rdy)
			@(negedge clk_2x_w);
		@(posedge clk_2x_w);
		bus_req <= '0;
		@(negedge clk_2x_w);
		rdata = bus_rsp.data;
		rdy = bus_rsp.rdy;
	endtask

	task automatic wait_release(input int limit, input string what, inout logic cold_seen);
		int n;
		n = 0;
		while (rst_out && n < limit) begin
			@(negedge clk_2x_w);
			if (cold_rst)
				cold_seen = 1'b1;
			n++;
		end
		if (rst_out) begin
			$display("ERROR: %s did not release rst_o within %0d cycles", what, limit);
			errors++;
		end
	endtask

	task automatic check_cleared(input string what);
		logic [31:0] rd;
		logic rdy;
		gpio_model = 8'd0;
		check_val(gp_out, 32'd0, {"gp_o after ", what});
		bus_access(soc_bus_pkg::RD, 10'd0, 32'd0, 4'hf, rd, rdy);
		check_val(rd, 32'd0, {"control register after ", what});
		bus_access(soc_bus_pkg::RD, 10'd64, 32'd0, 4'hf, rd, rdy);
		check_val(rd, 32'd0, {"GPIO register after ", what});
	endtask

	task automatic sw_reset(input logic [1:0] bits, input logic cold_exp, input string name);
		logic [31:0] rd;
		logic rdy;
		logic cold_seen;
		// A set GPIO register makes the clear visible
		bus_access(soc_bus_pkg::WR, 10'd64, 32'h5a, 4'h1, rd, rdy);
		gpio_model = 8'h5a;
		bus_access(soc_bus_pkg::WR, 10'd0, 32'(bits), 4'h1, rd, rdy);
		cold_seen = cold_rst;
		@(negedge clk_2x_w);
		cold_seen = cold_seen | cold_rst;
		check_val(rst_out, 32'd1, {"rst_o after ", name, " write"});
		wait_release(70, name, cold_seen);
		check_val(cold_seen, 32'(cold_exp), {"cold_rst_o during ", name, " reset"});
		check_cleared(name);
	endtask

	task automatic run_activity(input int cycles, input logic random_src);
		logic [31:0] r;
		logic di;
		logic dout;
		logic err;
		int i;
		for (i = 0; i < cycles; i++) begin
			r = lcg_next();
			di = random_src ? r[4] : 1'b1;
			dout = random_src ? r[9] : 1'b1;
			err = random_src && (r[14:12] == 3'd0);
			@(posedge clk_2x_w);
			// This edge sees the sources applied during the last cycle
			if (act_cnt) begin
				act_exp = 1'b0;
				act_cnt = 1'b0;
			end else begin
				act_exp = act_cond;
				act_cnt = act_cond;
			end
			sd_di <= di;
			sd_do <= dout;
			dram_init_error <= err;
			act_cond = ~(di & dout) | err;
			@(negedge clk_2x_w);
			check_val(gp_out, {gpio_model[7:1], gpio_model[0] | act_exp}, "gp_o with activity");
		end
	endtask

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] rd;
		logic rdy;
		logic [9:0] addr;
		logic stayed;
		logic cold_seen;
		int i;
		rst_p = 1'b1;
		pll_locked = 1'b0;
		cpu_rst_req = 1'b0;
		bus_req = '0;
		gp_in = 8'd0;
		sd_di = 1'b1;
		sd_do = 1'b1;
		dram_init_error = 1'b0;

		// Reset release
		@(posedge clk_2x_w);
		@(negedge clk_2x_w);
		check_val(rst_out, 32'd1, "rst_o with PLL unlocked");
		check_val(bus_rsp.rdy, 32'd0, "rdy in reset");
		check_val(cold_rst, 32'd0, "cold_rst_o in reset");
		check_val(gp_out, 32'd0, "gp_o in reset");
		@(posedge clk_2x_w);
		pll_locked <= 1'b1;
		@(posedge clk_2x_w);
		rst_p <= 1'b0;
		repeat (60) @(posedge clk_2x_w);
		@(negedge clk_2x_w);
		check_val(rst_out, 32'd1, "rst_o at cycle 60");
		repeat (6) @(posedge clk_2x_w);
		@(negedge clk_2x_w);
		check_val(rst_out, 32'd0, "rst_o at cycle 66");
		@(posedge clk_2x_w);
		pll_locked <= 1'b0;
		repeat (4) begin
			@(negedge clk_2x_w);
			check_val(rst_out, 32'd1, "rst_o after PLL loss");
		end
		@(posedge clk_2x_w);
		pll_locked <= 1'b1;
		@(negedge clk_2x_w);
		check_val(rst_out, 32'd0, "rst_o after PLL relock");
		check_cleared("power-up");
		test_end("reset release");

		for (i = 0; i < N_DEVTBL; i++) begin
			r = lcg_next();
			addr = 10'(r % 64);
			bus_access(soc_bus_pkg::RD, addr, 32'd0, 4'hf, rd, rdy);
			check_val(rd, devtbl_word(int'(addr)), $sformatf("device table word %0d", addr));
		end
		test_end("device table");

		for (i = 0; i < N_GPIO; i++) begin
			r = lcg_next();
			bus_access(soc_bus_pkg::WR, 10'd64, r, r[19:16], rd, rdy);
			if (r[16])
				gpio_model = r[7:0];
			check_val(gp_out, 32'(gpio_model), "gp_o after write");
			r = lcg_next();
			@(posedge clk_2x_w);
			gp_in <= r[7:0];
			repeat (3) @(posedge clk_2x_w);
			bus_access(soc_bus_pkg::RD, 10'd65, 32'd0, 4'hf, rd, rdy);
			check_val(rd, 32'(r[7:0]), "synchronized GPIO inputs");
		end
		test_end("gpio");

		for (i = 0; i < N_INVALID; i++) begin
			r = lcg_next();
			addr = 10'(128 + r % 896);
			bus_access(soc_bus_pkg::RD, addr, 32'd0, 4'hf, rd, rdy);
			check_val(rd, 32'd0, $sformatf("invalid word %0d", addr));
			check_val(rdy, 32'd1, "rdy on invalid read");
			r = lcg_next();
			addr = 10'(128 + r % 896);
			bus_access(soc_bus_pkg::WR, addr, r, 4'hf, rd, rdy);
		end
		bus_access(soc_bus_pkg::RD, 10'd0, 32'd0, 4'hf, rd, rdy);
		check_val(rd, 32'd0, "control register after invalid writes");
		bus_access(soc_bus_pkg::RD, 10'd64, 32'd0, 4'hf, rd, rdy);
		check_val(rd, 32'(gpio_model), "GPIO register after invalid writes");
		check_val(gp_out, 32'(gpio_model), "gp_o after invalid writes");
		test_end("invalid device");

		sw_reset(2'b10, 1'b0, "warm");
		sw_reset(2'b11, 1'b1, "cold");
		bus_access(soc_bus_pkg::WR, 10'd64, 32'ha5, 4'h1, rd, rdy);
		gpio_model = 8'ha5;
		bus_access(soc_bus_pkg::WR, 10'd0, 32'd1, 4'h1, rd, rdy);
		stayed = 1'b1;
		cold_seen = cold_rst;
		repeat (100) begin
			@(negedge clk_2x_w);
			if (!rst_out)
				stayed = 1'b0;
			if (cold_rst)
				cold_seen = 1'b1;
		end
		check_val(stayed, 32'd1, "rst_o held through power-off");
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		@(negedge clk_2x_w);
		wait_release(70, "power-off", cold_seen);
		check_val(cold_seen, 32'd0, "cold_rst_o during power-off");
		check_cleared("power-off");
		test_end("software resets");

		r = lcg_next();
		bus_access(soc_bus_pkg::WR, 10'd64, r & 32'hfe, 4'h1, rd, rdy);
		gpio_model = r[7:0] & 8'hfe;
		run_activity(N_ACT, 1'b1);
		run_activity(12, 1'b0);
		test_end("activity");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, assert_errors);
		if (errors == 0 && assert_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
